// File: common/mem_issue_defines.svh
`ifndef MEM_ISSUE_DEFINES_SVH
`define MEM_ISSUE_DEFINES_SVH

// Reservation station size
`define MEMRS_DEPTH 4

// Physical register file
`define PHY_REGS  32
`define PHY_IDX_W 5

// Reorder buffer id
`define ROB_ID_W 4

// Datapath widths
`define XLEN  32
`define IMM_W 12

// Number of result buses on the CDB
`define CDB_WIDTH 2

`endif

// File: common/mem_issue_itf.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

// Dispatch to reservation station
interface ds_rs_itf;
    logic                          valid;
    logic                          ready;
    mem_issue_pkg::mem_rs_entry_t  uop;

    modport ds (
        output valid,
        output uop,
        input  ready
    );

    modport rs (
        input  valid,
        input  uop,
        output ready
    );
endinterface

// Station operand read from the physical register file
interface rs_prf_itf;
    logic [`PHY_IDX_W-1:0] rs1_phy;
    logic [`PHY_IDX_W-1:0] rs2_phy;
    logic [`XLEN-1:0]      rs1_value;
    logic [`XLEN-1:0]      rs2_value;

    modport rs (
        output rs1_phy,
        output rs2_phy,
        input  rs1_value,
        input  rs2_value
    );

    modport prf (
        input  rs1_phy,
        input  rs2_phy,
        output rs1_value,
        output rs2_value
    );
endinterface

// One result bus of the CDB
interface cdb_itf;
    logic                  valid;
    logic [`PHY_IDX_W-1:0] phy;
    logic [`XLEN-1:0]      value;

    // Entries only need the tag for wakeup
    modport rs  (input valid, input phy);
    modport prf (input valid, input phy, input value);
endinterface

// File: common/mem_issue_pkg.sv
`include "mem_issue_defines.svh"

package mem_issue_pkg;

    // Memory micro-op opcodes
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    // One station entry, also the dispatch payload
    typedef struct packed {
        logic [`ROB_ID_W-1:0]  rob_id;
        logic [`PHY_IDX_W-1:0] rs1_phy;
        logic                  rs1_valid;
        logic [`PHY_IDX_W-1:0] rs2_phy;
        logic                  rs2_valid;
        logic [`IMM_W-1:0]     imm;
        mem_op_e               fu_opcode;
    } mem_rs_entry_t;

    // Issued micro-op with operand values, into the AGU
    typedef struct packed {
        logic [`ROB_ID_W-1:0] rob_id;
        mem_op_e              fu_opcode;
        logic [`IMM_W-1:0]    imm;
        logic [`XLEN-1:0]     rs1_value;
        logic [`XLEN-1:0]     rs2_value;
    } agu_reg_t;

    // AGU result toward the load/store queue
    typedef struct packed {
        logic [`ROB_ID_W-1:0] rob_id;
        mem_op_e              fu_opcode;
        logic [`XLEN-1:0]     addr;
        logic [`XLEN-1:0]     store_data;
    } agu_lsq_t;

    function automatic logic is_store(input mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

// File: logic/fu_agu.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module fu_agu (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      prv_valid,
    input  mem_issue_pkg::agu_reg_t   agu_reg_in,

    output logic                      nxt_valid,
    output mem_issue_pkg::agu_lsq_t   to_lsq
);

    mem_issue_pkg::agu_lsq_t  lsq_next;
    logic [`XLEN-1:0]         imm_sext;

    // Immediate is sign-extended up to XLEN
    assign imm_sext = {{(`XLEN-`IMM_W){agu_reg_in.imm[`IMM_W-1]}}, agu_reg_in.imm};

    always_comb begin
        lsq_next.rob_id    = agu_reg_in.rob_id;
        lsq_next.fu_opcode = agu_reg_in.fu_opcode;
        lsq_next.addr      = agu_reg_in.rs1_value + imm_sext;
        // Loads carry no store data
        if (mem_issue_pkg::is_store(agu_reg_in.fu_opcode)) begin
            lsq_next.store_data = agu_reg_in.rs2_value;
        end else begin
            lsq_next.store_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nxt_valid <= 1'b0;
        end else begin
            nxt_valid <= prv_valid;
        end
    end

    // Payload only moves when something issues
    always_ff @(posedge clk) begin
        if (prv_valid) begin
            to_lsq <= lsq_next;
        end
    end

endmodule

// File: logic/mem_issue_top.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module mem_issue_top (
    input  logic                                   clk,
    input  logic                                   reset,

    // Dispatch
    input  logic                                   ds_valid,
    output logic                                   ds_ready,
    input  logic [`ROB_ID_W-1:0]                   ds_rob_id,
    input  mem_issue_pkg::mem_op_e                 ds_opcode,
    input  logic [`PHY_IDX_W-1:0]                  ds_rs1_phy,
    input  logic                                   ds_rs1_valid,
    input  logic [`PHY_IDX_W-1:0]                  ds_rs2_phy,
    input  logic                                   ds_rs2_valid,
    input  logic [`IMM_W-1:0]                      ds_imm,

    // Common data bus
    input  logic [`CDB_WIDTH-1:0]                  cdb_valid,
    input  logic [`CDB_WIDTH-1:0][`PHY_IDX_W-1:0]  cdb_phy,
    input  logic [`CDB_WIDTH-1:0][`XLEN-1:0]       cdb_value,

    // Load/store queue
    output logic                                   lsq_valid,
    output logic [`ROB_ID_W-1:0]                   lsq_rob_id,
    output mem_issue_pkg::mem_op_e                 lsq_opcode,
    output logic [`XLEN-1:0]                       lsq_addr,
    output logic [`XLEN-1:0]                       lsq_store_data
);

    ds_rs_itf   ds_if ();
    rs_prf_itf  prf_if ();
    cdb_itf     cdb_bus [`CDB_WIDTH] ();

    logic                      agu_valid;
    mem_issue_pkg::agu_reg_t   agu_reg;
    mem_issue_pkg::agu_lsq_t   lsq_pkt;

    ////////////////////////////////////////////////////////////////////////////
    // Port mapping
    ////////////////////////////////////////////////////////////////////////////

    assign ds_if.valid = ds_valid;
    assign ds_ready    = ds_if.ready;
    assign ds_if.uop   = '{rob_id:    ds_rob_id,
                           rs1_phy:   ds_rs1_phy,
                           rs1_valid: ds_rs1_valid,
                           rs2_phy:   ds_rs2_phy,
                           rs2_valid: ds_rs2_valid,
                           imm:       ds_imm,
                           fu_opcode: ds_opcode};

    for (genvar c = 0; c < `CDB_WIDTH; c++) begin : cdb_map
        assign cdb_bus[c].valid = cdb_valid[c];
        assign cdb_bus[c].phy   = cdb_phy[c];
        assign cdb_bus[c].value = cdb_value[c];
    end

    assign lsq_rob_id     = lsq_pkt.rob_id;
    assign lsq_opcode     = lsq_pkt.fu_opcode;
    assign lsq_addr       = lsq_pkt.addr;
    assign lsq_store_data = lsq_pkt.store_data;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////

    mem_rs mem_rs_i (
        .clk       (clk),
        .reset     (reset),
        .from_ds   (ds_if),
        .cdb       (cdb_bus),
        .to_prf    (prf_if),
        .agu_valid (agu_valid),
        .agu_reg   (agu_reg)
    );

    prf prf_i (
        .clk   (clk),
        .reset (reset),
        .cdb   (cdb_bus),
        .rd    (prf_if)
    );

    fu_agu fu_agu_i (
        .clk        (clk),
        .reset      (reset),
        .prv_valid  (agu_valid),
        .agu_reg_in (agu_reg),
        .nxt_valid  (lsq_valid),
        .to_lsq     (lsq_pkt)
    );

endmodule

// File: logic/prf.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module prf (
    input  logic     clk,
    input  logic     reset,

    cdb_itf.prf      cdb[`CDB_WIDTH],
    rs_prf_itf.prf   rd
);

    ////////////////////////////////////////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////////////////////////////////////////

    logic [`XLEN-1:0]                       regs [`PHY_REGS];

    logic [`CDB_WIDTH-1:0]                  wr_valid;
    logic [`CDB_WIDTH-1:0][`PHY_IDX_W-1:0]  wr_phy;
    logic [`CDB_WIDTH-1:0][`XLEN-1:0]       wr_value;

    // One write port per result bus
    for (genvar c = 0; c < `CDB_WIDTH; c++) begin : cdb_unpack
        assign wr_valid[c] = cdb[c].valid;
        assign wr_phy[c]   = cdb[c].phy;
        assign wr_value[c] = cdb[c].value;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `PHY_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Higher bus wins if two buses name the same tag
            for (int c = 0; c < `CDB_WIDTH; c++) begin
                if (wr_valid[c]) begin
                    regs[wr_phy[c]] <= wr_value[c];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////////////

    assign rd.rs1_value = regs[rd.rs1_phy];
    assign rd.rs2_value = regs[rd.rs2_phy];

endmodule

// File: mem_rs/mem_rs.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module mem_rs (
    input  logic                     clk,
    input  logic                     reset,

    ds_rs_itf.rs                     from_ds,
    cdb_itf.rs                       cdb[`CDB_WIDTH],
    rs_prf_itf.rs                    to_prf,

    output logic                     agu_valid,
    output mem_issue_pkg::agu_reg_t  agu_reg
);

    ////////////////////////////////////////////////////////////////////////////
    // Station entries
    ////////////////////////////////////////////////////////////////////////////

    logic [`MEMRS_DEPTH-1:0]                              rs_valid;
    logic [`MEMRS_DEPTH-1:0]                              rs_request;
    logic [`MEMRS_DEPTH-1:0]                              rs_grant;
    logic [`MEMRS_DEPTH-1:0]                              rs_push_en;
    mem_issue_pkg::mem_rs_entry_t [`MEMRS_DEPTH-1:0]      rs_entry;
    mem_issue_pkg::mem_rs_entry_t                         issued_entry;
    logic [`MEMRS_DEPTH-1:0]                              free_mask;
    logic                                                 push;

    for (genvar i = 0; i < `MEMRS_DEPTH; i++) begin : rs_array
        rs_entry rs_entry_i (
            .clk        (clk),
            .reset      (reset),
            .push_en    (rs_push_en[i]),
            .entry_in   (from_ds.uop),
            .grant      (rs_grant[i]),
            .wakeup_cdb (cdb),
            .valid      (rs_valid[i]),
            .request    (rs_request[i]),
            .entry      (rs_entry[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Allocation and grant
    ////////////////////////////////////////////////////////////////////////////

    // Room for a push as long as one entry is free
    assign free_mask     = ~rs_valid;
    assign from_ds.ready = |free_mask;
    assign push          = from_ds.valid && from_ds.ready;

    // Isolate the lowest set bit with x & (~x + 1)
    assign rs_push_en = push ? (free_mask & (~free_mask + 1'b1)) : '0;
    assign rs_grant   = rs_request & (~rs_request + 1'b1);

    // Select the granted entry
    always_comb begin
        issued_entry = '0;
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            if (rs_grant[i]) begin
                issued_entry = rs_entry[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operand read and AGU input
    ////////////////////////////////////////////////////////////////////////////

    assign to_prf.rs1_phy = issued_entry.rs1_phy;
    assign to_prf.rs2_phy = issued_entry.rs2_phy;

    assign agu_valid = |rs_request;

    always_comb begin
        agu_reg.rob_id    = issued_entry.rob_id;
        agu_reg.fu_opcode = issued_entry.fu_opcode;
        agu_reg.imm       = issued_entry.imm;
        agu_reg.rs1_value = to_prf.rs1_value;
        agu_reg.rs2_value = to_prf.rs2_value;
    end

endmodule

// File: mem_rs/rs_entry.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module rs_entry (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          push_en,
    input  mem_issue_pkg::mem_rs_entry_t  entry_in,
    input  logic                          grant,
    cdb_itf.rs                            wakeup_cdb[`CDB_WIDTH],

    output logic                          valid,
    output logic                          request,
    output mem_issue_pkg::mem_rs_entry_t  entry
);

    logic [`CDB_WIDTH-1:0]                  cdb_valid;
    logic [`CDB_WIDTH-1:0][`PHY_IDX_W-1:0]  cdb_phy;
    logic                                   rs1_hit;
    logic                                   rs2_hit;
    logic                                   in_rs1_hit;
    logic                                   in_rs2_hit;

    // Flatten the bus array so it can be scanned in a loop
    for (genvar c = 0; c < `CDB_WIDTH; c++) begin : cdb_unpack
        assign cdb_valid[c] = wakeup_cdb[c].valid;
        assign cdb_phy[c]   = wakeup_cdb[c].phy;
    end

    function automatic logic tag_hit(
        input logic [`CDB_WIDTH-1:0]                  v,
        input logic [`CDB_WIDTH-1:0][`PHY_IDX_W-1:0]  p,
        input logic [`PHY_IDX_W-1:0]                  tag
    );
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < `CDB_WIDTH; c++) begin
            hit |= v[c] && (p[c] == tag);
        end
        return hit;
    endfunction

    // Wakeup for the held entry and for an incoming push
    assign rs1_hit    = tag_hit(cdb_valid, cdb_phy, entry.rs1_phy);
    assign rs2_hit    = tag_hit(cdb_valid, cdb_phy, entry.rs2_phy);
    assign in_rs1_hit = tag_hit(cdb_valid, cdb_phy, entry_in.rs1_phy);
    assign in_rs2_hit = tag_hit(cdb_valid, cdb_phy, entry_in.rs2_phy);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (push_en) begin
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            entry           <= entry_in;
            entry.rs1_valid <= entry_in.rs1_valid | in_rs1_hit;
            entry.rs2_valid <= entry_in.rs2_valid | in_rs2_hit;
        end else begin
            if (rs1_hit) entry.rs1_valid <= 1'b1;
            if (rs2_hit) entry.rs2_valid <= 1'b1;
        end
    end

    assign request = valid && entry.rs1_valid && entry.rs2_valid;

endmodule

// File: sim/mem_issue_props.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module mem_issue_props (
    input logic                     clk,
    input logic                     reset,
    input logic [`MEMRS_DEPTH-1:0]  valid,
    input logic [`MEMRS_DEPTH-1:0]  grant,
    input logic                     push,
    input logic                     agu_valid
);

    // Count of failed assertions
    int fail_count = 0;

    // At most one entry issues per cycle
    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else begin
            $error("more than one station entry granted in one cycle");
            fail_count = fail_count + 1;
        end

    // A full station accepts nothing
    no_push_when_full: assert property (@(posedge clk) disable iff (reset) (&valid) |-> !push)
        else begin
            $error("push into a full reservation station");
            fail_count = fail_count + 1;
        end

    // Nothing reaches the AGU right after reset
    quiet_after_reset: assert property (@(posedge clk) reset |=> !agu_valid)
        else begin
            $error("AGU valid raised in the cycle after reset");
            fail_count = fail_count + 1;
        end

endmodule

bind mem_rs mem_issue_props props_i (
    .clk       (clk),
    .reset     (reset),
    .valid     (rs_valid),
    .grant     (rs_grant),
    .push      (push),
    .agu_valid (agu_valid)
);

// File: sim/mem_issue_tb.sv
`timescale 1ns/1ns
`include "mem_issue_defines.svh"

module mem_issue_tb;

    localparam int MAX_CYCLES    = 4000;
    localparam int RANDOM_CYCLES = 900;
    // Registers below the split hold fixed values and the rest serve as pending tags
    localparam int POOL_SPLIT    = `PHY_REGS / 2;
    localparam int ROB_IDS       = 2 ** `ROB_ID_W;

    logic                                   clk;
    logic                                   reset;
    logic                                   ds_valid;
    logic                                   ds_ready;
    logic [`ROB_ID_W-1:0]                   ds_rob_id;
    mem_issue_pkg::mem_op_e                 ds_opcode;
    logic [`PHY_IDX_W-1:0]                  ds_rs1_phy;
    logic                                   ds_rs1_valid;
    logic [`PHY_IDX_W-1:0]                  ds_rs2_phy;
    logic                                   ds_rs2_valid;
    logic [`IMM_W-1:0]                      ds_imm;
    logic [`CDB_WIDTH-1:0]                  cdb_valid;
    logic [`CDB_WIDTH-1:0][`PHY_IDX_W-1:0]  cdb_phy;
    logic [`CDB_WIDTH-1:0][`XLEN-1:0]       cdb_value;
    logic                                   lsq_valid;
    logic [`ROB_ID_W-1:0]                   lsq_rob_id;
    mem_issue_pkg::mem_op_e                 lsq_opcode;
    logic [`XLEN-1:0]                       lsq_addr;
    logic [`XLEN-1:0]                       lsq_store_data;

    integer                   seed = 32'he8bb_4a3b;
    int                       cycles = 0;
    int                       dispatched_count = 0;
    int                       issued_count = 0;
    int                       outstanding;
    logic [`ROB_ID_W-1:0]     next_rob = '0;
    logic [`XLEN-1:0]         model_regs [`PHY_REGS];
    logic                     tag_busy [`PHY_REGS];
    logic [`PHY_IDX_W-1:0]    pending_tags [$];

    // Scoreboard indexed by ROB id
    logic                     sb_valid [ROB_IDS];
    mem_issue_pkg::mem_op_e   sb_op [ROB_IDS];
    logic [`PHY_IDX_W-1:0]    sb_rs1 [ROB_IDS];
    logic [`PHY_IDX_W-1:0]    sb_rs2 [ROB_IDS];
    logic                     sb_rs1_pend [ROB_IDS];
    logic                     sb_rs2_pend [ROB_IDS];
    logic [`IMM_W-1:0]        sb_imm [ROB_IDS];
    logic [`ROB_ID_W-1:0]     cmp_rob;
    logic [2*`XLEN-1:0]       cmp_exp;

    mem_issue_top uut (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic is_store_op(input mem_issue_pkg::mem_op_e op);
        case (op)
            mem_issue_pkg::SB, mem_issue_pkg::SH, mem_issue_pkg::SW: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Address in the upper half and store data in the lower half
    function automatic logic [2*`XLEN-1:0] agu_expect(
        input mem_issue_pkg::mem_op_e op,
        input logic [`XLEN-1:0]       base,
        input logic [`XLEN-1:0]       data,
        input logic [`IMM_W-1:0]      imm
    );
        int               offset;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] store_data;
        offset     = $signed(imm);
        addr       = base + offset;
        store_data = is_store_op(op) ? data : '0;
        return {addr, store_data};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "stopping at first error");
        end
    endtask

    // First free pending tag from a random start or zero when none is left
    function automatic logic [`PHY_IDX_W-1:0] find_free_tag(input int start,
                                                           input logic [4:0] skip);
        logic [`PHY_IDX_W-1:0] t;
        logic [`PHY_IDX_W-1:0] found;
        found = '0;
        for (int k = 0; k < POOL_SPLIT; k++) begin
            t = POOL_SPLIT + (($unsigned(start) + k) % POOL_SPLIT);
            if (!tag_busy[t] && t != skip && found == 0) begin
                found = t;
            end
        end
        return found;
    endfunction

    // Scoreboard compare on every LSQ output
    always @(posedge clk) begin
        if (!reset && lsq_valid === 1'b1) begin
            cmp_rob = lsq_rob_id;
            if (!sb_valid[cmp_rob]) begin
                $display("LSQ output carries ROB id %0d, which is not in flight", cmp_rob);
                $display("Finished with errors");
                $fatal(1, "unexpected issue");
            end else begin
                cmp_exp = agu_expect(sb_op[cmp_rob], model_regs[sb_rs1[cmp_rob]],
                                     model_regs[sb_rs2[cmp_rob]], sb_imm[cmp_rob]);
                check_value($sformatf("opcode rob %0d", cmp_rob), sb_op[cmp_rob], lsq_opcode);
                check_value($sformatf("address rob %0d", cmp_rob), cmp_exp[63:32], lsq_addr);
                check_value($sformatf("store data rob %0d", cmp_rob), cmp_exp[31:0],
                            lsq_store_data);
                if (sb_rs1_pend[cmp_rob]) tag_busy[sb_rs1[cmp_rob]] = 1'b0;
                if (sb_rs2_pend[cmp_rob]) tag_busy[sb_rs2[cmp_rob]] = 1'b0;
                sb_valid[cmp_rob] = 1'b0;
                issued_count      = issued_count + 1;
            end
        end
    end

    // Watchdog that also picks up failed assertions
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end else if (uut.mem_rs_i.props_i.fail_count != 0) begin
            $display("an assertion on the reservation station failed");
            $display("Finished with errors");
            $fatal(1, "assertion failure");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle;
        @(negedge clk);
        ds_valid  = 1'b0;
        cdb_valid = '0;
    endtask

    task automatic put_cdb(input int bus, input logic [4:0] tag, input logic [31:0] value);
        cdb_valid[bus]  = 1'b1;
        cdb_phy[bus]    = tag;
        cdb_value[bus]  = value;
        model_regs[tag] = value;
    endtask

    // Offers one micro-op and acc tells if it goes in at the coming edge
    task automatic put_uop(input mem_issue_pkg::mem_op_e op,
                           input logic [4:0] rs1, input logic rs1_rdy,
                           input logic [4:0] rs2, input logic rs2_rdy,
                           input logic [11:0] imm, output logic acc);
        ds_valid     = 1'b1;
        ds_rob_id    = next_rob;
        ds_opcode    = op;
        ds_rs1_phy   = rs1;
        ds_rs1_valid = rs1_rdy;
        ds_rs2_phy   = rs2;
        ds_rs2_valid = rs2_rdy;
        ds_imm       = imm;
        acc          = (ds_ready === 1'b1);
        if (acc) begin
            sb_valid[next_rob]    = 1'b1;
            sb_op[next_rob]       = op;
            sb_rs1[next_rob]      = rs1;
            sb_rs2[next_rob]      = rs2;
            sb_rs1_pend[next_rob] = !rs1_rdy;
            sb_rs2_pend[next_rob] = !rs2_rdy;
            sb_imm[next_rob]      = imm;
            if (!rs1_rdy) tag_busy[rs1] = 1'b1;
            if (!rs2_rdy) tag_busy[rs2] = 1'b1;
            next_rob         = next_rob + 1'b1;
            dispatched_count = dispatched_count + 1;
        end
    endtask

    task automatic wait_drain;
        while (issued_count != dispatched_count) begin
            next_cycle;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_ready_regs;
        for (int r = 0; r < POOL_SPLIT; r += 2) begin
            next_cycle;
            put_cdb(0, r, $random(seed));
            put_cdb(1, r + 1, $random(seed));
        end
        next_cycle;
    endtask

    // Ready operands reach the LSQ one clock after the accepting edge
    task automatic test_ready_issue;
        logic acc;
        for (int i = 0; i < 4; i++) begin
            next_cycle;
            put_uop((i % 2) ? mem_issue_pkg::SW : mem_issue_pkg::LH,
                    $unsigned($random(seed)) % POOL_SPLIT, 1'b1,
                    $unsigned($random(seed)) % POOL_SPLIT, 1'b1, $random(seed), acc);
            check_value("ready dispatch accepted", 1, acc);
            next_cycle;
            check_value("lsq_valid before latency", 0, lsq_valid);
            next_cycle;
            check_value("lsq_valid latency", 1, lsq_valid);
        end
        wait_drain;
    endtask

    task automatic test_pending_wakeup;
        logic acc;
        next_cycle;
        put_uop(mem_issue_pkg::SW, 16, 1'b0, 17, 1'b0, 12'hff0, acc);
        check_value("pending dispatch accepted", 1, acc);
        repeat (3) begin
            next_cycle;
            check_value("lsq_valid while both pending", 0, lsq_valid);
        end
        put_cdb(0, 16, $random(seed));
        repeat (2) begin
            next_cycle;
            check_value("lsq_valid while rs2 pending", 0, lsq_valid);
        end
        put_cdb(1, 17, $random(seed));
        wait_drain;
        // Wakeup in the push cycle on either bus
        next_cycle;
        put_uop(mem_issue_pkg::LW, 18, 1'b0, 3, 1'b1, 12'h024, acc);
        put_cdb(0, 18, $random(seed));
        check_value("same-cycle load accepted", 1, acc);
        wait_drain;
        next_cycle;
        put_uop(mem_issue_pkg::SH, 5, 1'b1, 19, 1'b0, 12'h800, acc);
        put_cdb(1, 19, $random(seed));
        check_value("same-cycle store accepted", 1, acc);
        wait_drain;
    endtask

    task automatic test_station_full;
        logic acc;
        for (int i = 0; i < `MEMRS_DEPTH; i++) begin
            next_cycle;
            put_uop(mem_issue_pkg::SB, 20 + 2 * i, 1'b0, 21 + 2 * i, 1'b0, $random(seed), acc);
            check_value("fill dispatch accepted", 1, acc);
        end
        repeat (3) begin
            next_cycle;
            check_value("ds_ready when full", 0, ds_ready);
            put_uop(mem_issue_pkg::LBU, 1, 1'b1, 2, 1'b1, 12'h010, acc);
            check_value("held dispatch accepted", 0, acc);
        end
        // Wake the oldest entry and keep offering until there is room
        next_cycle;
        put_cdb(0, 20, $random(seed));
        put_cdb(1, 21, $random(seed));
        put_uop(mem_issue_pkg::LBU, 1, 1'b1, 2, 1'b1, 12'h010, acc);
        while (!acc) begin
            next_cycle;
            put_uop(mem_issue_pkg::LBU, 1, 1'b1, 2, 1'b1, 12'h010, acc);
        end
        for (int t = 22; t < 28; t += 2) begin
            next_cycle;
            put_cdb(0, t, $random(seed));
            put_cdb(1, t + 1, $random(seed));
        end
        wait_drain;
    endtask

    task automatic offer_random;
        logic [2:0]             r3;
        mem_issue_pkg::mem_op_e op;
        logic                   r1_rdy;
        logic                   r2_rdy;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic                   acc;
        r3     = $random(seed);
        op     = mem_issue_pkg::mem_op_e'(r3);
        r1_rdy = $random(seed);
        r2_rdy = is_store_op(op) ? $random(seed) : 1'b1;
        rs1    = $unsigned($random(seed)) % POOL_SPLIT;
        rs2    = $unsigned($random(seed)) % POOL_SPLIT;
        if (!r1_rdy) begin
            rs1 = find_free_tag($random(seed), 5'd0);
            if (rs1 == 0) r1_rdy = 1'b1;
        end
        if (!r2_rdy) begin
            rs2 = find_free_tag($random(seed), rs1);
            if (rs2 == 0) r2_rdy = 1'b1;
        end
        put_uop(op, rs1, r1_rdy, rs2, r2_rdy, $random(seed), acc);
        if (acc && !r1_rdy) pending_tags.push_back(rs1);
        if (acc && !r2_rdy) pending_tags.push_back(rs2);
    endtask

    task automatic broadcast_random;
        int         idx;
        logic [4:0] tag;
        for (int b = 0; b < `CDB_WIDTH; b++) begin
            if (pending_tags.size() != 0 && ($random(seed) & 1)) begin
                idx = $unsigned($random(seed)) % pending_tags.size();
                tag = pending_tags[idx];
                pending_tags.delete(idx);
                put_cdb(b, tag, $random(seed));
            end
        end
    endtask

    task automatic run_random(input int n_cycles);
        for (int n = 0; n < n_cycles; n++) begin
            next_cycle;
            if (($random(seed) & 3) != 0 && !sb_valid[next_rob]) offer_random;
            broadcast_random;
        end
        while (issued_count != dispatched_count) begin
            next_cycle;
            broadcast_random;
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ds_valid     = 1'b0;
        ds_rob_id    = '0;
        ds_opcode    = mem_issue_pkg::LB;
        ds_rs1_phy   = '0;
        ds_rs1_valid = 1'b0;
        ds_rs2_phy   = '0;
        ds_rs2_valid = 1'b0;
        ds_imm       = '0;
        cdb_valid    = '0;
        cdb_phy      = '0;
        cdb_value    = '0;
        for (int r = 0; r < `PHY_REGS; r++) begin
            model_regs[r] = '0;
            tag_busy[r]   = 1'b0;
        end
        for (int i = 0; i < ROB_IDS; i++) begin
            sb_valid[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        reset = 1'b0;
        next_cycle;
        check_value("lsq_valid after reset", 0, lsq_valid);
        check_value("ds_ready after reset", 1, ds_ready);
        load_ready_regs;
        test_ready_issue;
        test_pending_wakeup;
        test_station_full;
        run_random(RANDOM_CYCLES);
        outstanding = 0;
        for (int i = 0; i < ROB_IDS; i++) begin
            if (sb_valid[i]) outstanding = outstanding + 1;
        end
        if (outstanding != 0 || issued_count != dispatched_count) begin
            $display("%0d micro-ops still outstanding at the end of the run", outstanding);
            $display("Finished with errors");
            $fatal(1, "scoreboard not empty");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+common
common/mem_issue_pkg.sv
common/mem_issue_itf.sv
mem_rs/rs_entry.sv
mem_rs/mem_rs.sv
logic/prf.sv
logic/fu_agu.sv
logic/mem_issue_top.sv
sim/mem_issue_props.sv
sim/mem_issue_tb.sv
